/* verilog/adc_xy_pkg.sv */
package adc_xy_pkg;

  // adc front end
  localparam int ADC_BITS = 10;

  // frame buffer in pixels
  localparam int FB_W = 64;
  localparam int FB_H = 48;
  localparam int COORD_BITS = $clog2(FB_W);

  // clk cycles per pixel
  localparam int PIX_DIV = 4;

  // horizontal timing in pixels
  localparam int H_VISIBLE = FB_W;
  localparam int H_FRONT = 8;
  localparam int H_SYNC = 8;
  localparam int H_BACK = 16;
  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + H_SYNC;

  // vertical timing in lines
  localparam int V_VISIBLE = FB_H;
  localparam int V_FRONT = 2;
  localparam int V_SYNC = 2;
  localparam int V_BACK = 4;
  localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

  typedef logic [ADC_BITS-1:0] adc_word_t;
  typedef logic [COORD_BITS-1:0] coord_t;
  // y in the upper half, x in the lower half
  typedef logic [2*COORD_BITS-1:0] fb_addr_t;
  typedef logic [3:0] color_t;
  // red 11:8, green 7:4, blue 3:0
  typedef logic [11:0] pixel_t;
  typedef logic [6:0] hcount_t;
  typedef logic [5:0] vcount_t;

  typedef struct packed {
    fb_addr_t addr;
    pixel_t   pixel;
  } plot_t;

  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    logic    visible;
    logic    hsync;
    logic    vsync;
  } vga_pos_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_WRITE,
    ARB_ACK
  } arb_state_e;

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,
    HS_RELEASE
  } hs_state_e;

endpackage

/* verilog/adc_sample.sv */
module adc_sample
  import adc_xy_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      adc_clk,
  input  adc_word_t adc_x,
  input  adc_word_t adc_y,
  input  logic      adc_red,
  input  logic      adc_grn,
  input  logic      adc_blu,
  output logic      plot_req,
  output plot_t     plot,
  input  logic      plot_ack
);

  logic [1:0] adc_sync;
  logic       adc_prev;
  logic       adc_strobe;
  hs_state_e  hs_state;
  logic       take;

  coord_t     pt_x;
  coord_t     pt_y;
  logic [7:0] y_mul;
  pixel_t     pt_pixel;

  // adc_clk is asynchronous to clk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      adc_sync <= 2'b00;
      adc_prev <= 1'b0;
    end else begin
      adc_sync <= {adc_sync[0], adc_clk};
      adc_prev <= adc_sync[1];
    end
  end

  assign adc_strobe = adc_sync[1] && !adc_prev;

  // strobes during a handshake are dropped
  assign take = adc_strobe && (hs_state == HS_IDLE);

  // top six bits of x, y scaled by 3/4 onto 48 rows
  assign pt_x     = adc_x[ADC_BITS-1 -: COORD_BITS];
  assign y_mul    = {2'b00, adc_y[ADC_BITS-1 -: COORD_BITS]}
                  + {1'b0, adc_y[ADC_BITS-1 -: COORD_BITS], 1'b0};
  assign pt_y     = y_mul[7:2];
  assign pt_pixel = {{4{adc_red}}, {4{adc_grn}}, {4{adc_blu}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_state <= HS_IDLE;
    end else begin
      case (hs_state)
        HS_IDLE: begin
          if (take) begin
            hs_state <= HS_REQ;
          end
        end
        HS_REQ: begin
          if (plot_ack) begin
            hs_state <= HS_RELEASE;
          end
        end
        HS_RELEASE: begin
          if (!plot_ack) begin
            hs_state <= HS_IDLE;
          end
        end
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  // held stable for the whole request
  always_ff @(posedge clk) begin
    if (take) begin
      plot.addr  <= {pt_y, pt_x};
      plot.pixel <= pt_pixel;
    end
  end

  assign plot_req = (hs_state == HS_REQ);

endmodule

/* verilog/fb_arbiter.sv */
module fb_arbiter
  import adc_xy_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] phase,

  // scan-out read port
  input  logic       rd_strobe,
  input  fb_addr_t   rd_addr,
  output pixel_t     rd_data,

  // plot write port
  input  logic       plot_req,
  input  plot_t      plot,
  output logic       plot_ack,

  // sram pins
  output fb_addr_t   sram_addr,
  output pixel_t     sram_data_out,
  input  pixel_t     sram_data_in,
  output logic       sram_data_oe,
  output logic       sram_we_n,
  output logic       sram_oe_n,
  output logic       sram_ce_n
);

  arb_state_e state;
  logic       rd_go;
  logic       wr_go;

  // read owns phases 0 and 1
  assign rd_go = rd_strobe && (phase == 2'd0);

  // write pins are set up at the end of phase 1 so the pulse lands in phase 2
  assign wr_go = (state == ARB_IDLE) && plot_req && (phase == 2'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (wr_go) begin
            state <= ARB_WRITE;
          end
        end
        // we_n is low for this one cycle
        ARB_WRITE: begin
          state <= ARB_ACK;
        end
        ARB_ACK: begin
          if (!plot_req) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  assign plot_ack = (state == ARB_ACK);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sram_oe_n    <= 1'b1;
      sram_we_n    <= 1'b1;
      sram_data_oe <= 1'b0;
      sram_ce_n    <= 1'b1;
    end else begin
      sram_oe_n    <= !rd_go;
      sram_we_n    <= !wr_go;
      sram_data_oe <= wr_go;
      sram_ce_n    <= !(rd_go || wr_go);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      sram_addr <= rd_addr;
    end else if (wr_go) begin
      sram_addr     <= plot.addr;
      sram_data_out <= plot.pixel;
    end
  end

  // phase 1, sram output has settled
  always_ff @(posedge clk) begin
    if (!sram_oe_n) begin
      rd_data <= sram_data_in;
    end
  end

endmodule

/* verilog/vga_timing.sv */
module vga_timing
  import adc_xy_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  output logic       pix_en,
  output logic [1:0] phase,
  output vga_pos_t   pos
);

  hcount_t hcount;
  vcount_t vcount;
  logic    h_last;
  logic    v_last;

  // clock enable divider
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= 2'd0;
    end else if (phase == 2'(PIX_DIV - 1)) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  assign pix_en = (phase == 2'd0);

  assign h_last = (hcount == hcount_t'(H_TOTAL - 1));
  assign v_last = (vcount == vcount_t'(V_TOTAL - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
    end else if (pix_en) begin
      if (h_last) begin
        hcount <= '0;
        if (v_last) begin
          vcount <= '0;
        end else begin
          vcount <= vcount + 1'b1;
        end
      end else begin
        hcount <= hcount + 1'b1;
      end
    end
  end

  // both syncs active low
  always_comb begin
    pos.hcount  = hcount;
    pos.vcount  = vcount;
    pos.visible = (hcount < hcount_t'(H_VISIBLE)) && (vcount < vcount_t'(V_VISIBLE));
    pos.hsync   = !((hcount >= hcount_t'(H_SYNC_START)) &&
                    (hcount < hcount_t'(H_SYNC_END)));
    pos.vsync   = !((vcount >= vcount_t'(V_SYNC_START)) &&
                    (vcount < vcount_t'(V_SYNC_END)));
  end

endmodule

/* verilog/vga_scanout.sv */
module vga_scanout
  import adc_xy_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     pix_en,
  input  vga_pos_t pos,
  output logic     rd_strobe,
  output fb_addr_t rd_addr,
  input  pixel_t   rd_data,
  output color_t   vga_red,
  output color_t   vga_grn,
  output color_t   vga_blu,
  output logic     vga_hsync,
  output logic     vga_vsync
);

  logic   rd_q1;
  logic   rd_q2;
  pixel_t pix_q;
  logic   vis_d;
  logic   hs_d;
  logic   vs_d;

  // no read outside the visible area
  assign rd_strobe = pix_en && pos.visible;
  assign rd_addr   = {coord_t'(pos.vcount), coord_t'(pos.hcount)};

  // read data returns two cycles after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q1 <= 1'b0;
      rd_q2 <= 1'b0;
    end else begin
      rd_q1 <= rd_strobe;
      rd_q2 <= rd_q1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_q2) begin
      pix_q <= rd_data;
    end
  end

  // flags of the pixel being fetched
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vis_d <= 1'b0;
      hs_d  <= 1'b1;
      vs_d  <= 1'b1;
    end else if (pix_en) begin
      vis_d <= pos.visible;
      hs_d  <= pos.hsync;
      vs_d  <= pos.vsync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else if (pix_en) begin
      vga_red   <= vis_d ? pix_q[11:8] : '0;
      vga_grn   <= vis_d ? pix_q[7:4] : '0;
      vga_blu   <= vis_d ? pix_q[3:0] : '0;
      vga_hsync <= hs_d;
      vga_vsync <= vs_d;
    end
  end

endmodule

/* verilog/adc_xy_vga_top.sv */
module adc_xy_vga_top
  import adc_xy_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // adc front end
  input  logic      adc_clk,
  input  adc_word_t adc_x,
  input  adc_word_t adc_y,
  input  logic      adc_red,
  input  logic      adc_grn,
  input  logic      adc_blu,

  // sram
  output fb_addr_t  sram_addr,
  output pixel_t    sram_data_out,
  input  pixel_t    sram_data_in,
  output logic      sram_data_oe,
  output logic      sram_we_n,
  output logic      sram_oe_n,
  output logic      sram_ce_n,

  // vga
  output color_t    vga_red,
  output color_t    vga_grn,
  output color_t    vga_blu,
  output logic      vga_hsync,
  output logic      vga_vsync
);

  logic       plot_req;
  plot_t      plot;
  logic       plot_ack;
  logic       pix_en;
  logic [1:0] phase;
  vga_pos_t   pos;
  logic       rd_strobe;
  fb_addr_t   rd_addr;
  pixel_t     rd_data;

  adc_sample u_adc_sample (
    .clk     (clk),
    .rst_n   (rst_n),
    .adc_clk (adc_clk),
    .adc_x   (adc_x),
    .adc_y   (adc_y),
    .adc_red (adc_red),
    .adc_grn (adc_grn),
    .adc_blu (adc_blu),
    .plot_req(plot_req),
    .plot    (plot),
    .plot_ack(plot_ack)
  );

  fb_arbiter u_fb_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .phase        (phase),
    .rd_strobe    (rd_strobe),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .plot_req     (plot_req),
    .plot         (plot),
    .plot_ack     (plot_ack),
    .sram_addr    (sram_addr),
    .sram_data_out(sram_data_out),
    .sram_data_in (sram_data_in),
    .sram_data_oe (sram_data_oe),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  vga_timing u_vga_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .pix_en(pix_en),
    .phase (phase),
    .pos   (pos)
  );

  vga_scanout u_vga_scanout (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_en   (pix_en),
    .pos      (pos),
    .rd_strobe(rd_strobe),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

endmodule

/* tb/adc_xy_vga_properties.sv */
module adc_xy_vga_properties (
  input logic       clk,
  input logic       rst_n,
  input logic [1:0] phase,
  input logic       plot_req,
  input logic       plot_ack,
  input logic       sram_we_n,
  input logic       sram_oe_n,
  input logic       sram_data_oe
);

  // ack only answers a live request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(plot_ack) |-> plot_req)
    else $error("plot_ack rose while plot_req was low");

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    plot_req && !plot_ack |=> plot_req)
    else $error("plot_req dropped before plot_ack");

  no_bus_fight: assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram_we_n && !sram_oe_n))
    else $error("sram_we_n and sram_oe_n low together");

  // data bus driven only for the write pulse in phase 2
  oe_with_write: assert property (@(posedge clk) disable iff (!rst_n)
    sram_data_oe |-> !sram_we_n && (phase == 2'd2))
    else $error("sram_data_oe high outside a phase 2 write pulse");

endmodule

/* tb/adc_xy_vga_checker.sv */
module adc_xy_vga_checker
  import adc_xy_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input fb_addr_t sram_addr,
  input pixel_t   sram_data_out,
  input logic     sram_data_oe,
  input logic     sram_we_n,
  input logic     sram_oe_n,
  input logic     sram_ce_n,
  input color_t   vga_red,
  input color_t   vga_grn,
  input color_t   vga_blu,
  input logic     vga_hsync,
  input logic     vga_vsync
);

  localparam int MAX_REC = 32;
  localparam int H_CLKS = H_TOTAL * PIX_DIV;

  logic [15:0] stim [0:6*MAX_REC-1];
  plot_t       expect_q [$];
  pixel_t      shadow [0:4095];
  int          num_rec = 0;
  int          writes_seen = 0;
  int          write_errs = 0;
  int          sync_errs = 0;
  int          video_errs = 0;
  int          reset_errs = 0;
  logic        rst_low;
  logic        hs_prev = 1'b1;
  logic        vs_prev = 1'b1;
  logic        h_known = 1'b0;
  logic        v_known = 1'b0;
  // clk count within a line and line number, both from the syncs
  int          h_clk = 0;
  int          v_line = 0;

  always @(posedge clk) begin
    rst_low <= !rst_n;
  end

  function automatic bit value_differs(input string name, input logic [15:0] got,
                                       input logic [15:0] want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at time %0t",
               name, got, want, $time);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic color_t channel_level(input logic on);
    return on ? 4'hf : 4'h0;
  endfunction

  // x from the top six bits, y scaled by three quarters
  function automatic plot_t map_record(input int idx);
    plot_t p;
    int    x;
    int    y;
    x = int'(stim[idx*6][9:4]);
    y = (int'(stim[idx*6+1][9:4]) * 3) / 4;
    p.addr  = fb_addr_t'(y * FB_W + x);
    p.pixel = {channel_level(stim[idx*6+2][0]), channel_level(stim[idx*6+3][0]),
               channel_level(stim[idx*6+4][0])};
    return p;
  endfunction

  task automatic check_reset_values();
    reset_errs += int'(value_differs("sram_we_n", 16'(sram_we_n), 16'h1));
    reset_errs += int'(value_differs("sram_oe_n", 16'(sram_oe_n), 16'h1));
    reset_errs += int'(value_differs("sram_ce_n", 16'(sram_ce_n), 16'h1));
    reset_errs += int'(value_differs("sram_data_oe", 16'(sram_data_oe), 16'h0));
    reset_errs += int'(value_differs("vga_hsync", 16'(vga_hsync), 16'h1));
    reset_errs += int'(value_differs("vga_vsync", 16'(vga_vsync), 16'h1));
    reset_errs += int'(value_differs("vga_rgb", 16'({vga_red, vga_grn, vga_blu}), 16'h0));
  endtask

  task automatic check_write();
    plot_t want;
    if (!sram_we_n && !sram_ce_n) begin
      writes_seen++;
      if (expect_q.size() == 0) begin
        $display("SRAM write at time %0t with no stim record left to store", $time);
        write_errs++;
      end else begin
        want = expect_q.pop_front();
        write_errs += int'(value_differs("sram_addr", 16'(sram_addr), 16'(want.addr)));
        write_errs += int'(value_differs("sram_data_out", 16'(sram_data_out),
                                         16'(want.pixel)));
        write_errs += int'(value_differs("sram_data_oe", 16'(sram_data_oe), 16'h1));
        shadow[want.addr] = want.pixel;
      end
    end
  endtask

  task automatic track_video();
    int     hpix;
    logic   want_hs;
    logic   want_vs;
    pixel_t want;
    if (h_known) begin
      h_clk = (h_clk + 1) % H_CLKS;
      if (h_clk == 0) begin
        v_line = (v_line + 1) % V_TOTAL;
      end
    end else if (hs_prev && !vga_hsync) begin
      h_known = 1'b1;
      h_clk   = H_SYNC_START * PIX_DIV;
    end
    // vsync falls on the first pixel of its line
    if (h_known && !v_known && vs_prev && !vga_vsync) begin
      v_known = 1'b1;
      v_line  = V_SYNC_START;
    end
    hs_prev = vga_hsync;
    vs_prev = vga_vsync;
    if (h_known) begin
      want_hs = !(h_clk >= H_SYNC_START * PIX_DIV && h_clk < H_SYNC_END * PIX_DIV);
      sync_errs += int'(value_differs("vga_hsync", 16'(vga_hsync), 16'(want_hs)));
    end
    if (v_known) begin
      want_vs = !(v_line >= V_SYNC_START && v_line < V_SYNC_END);
      sync_errs += int'(value_differs("vga_vsync", 16'(vga_vsync), 16'(want_vs)));
      hpix = h_clk / PIX_DIV;
      want = '0;
      if (hpix < H_VISIBLE && v_line < V_VISIBLE) begin
        want = shadow[v_line * FB_W + hpix];
      end
      video_errs += int'(value_differs("vga_red", 16'(vga_red), 16'(want[11:8])));
      video_errs += int'(value_differs("vga_grn", 16'(vga_grn), 16'(want[7:4])));
      video_errs += int'(value_differs("vga_blu", 16'(vga_blu), 16'(want[3:0])));
    end
  endtask

  initial begin
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = '0;
    end
    for (int i = 0; i < 6 * MAX_REC; i++) begin
      stim[i] = 16'hffff;
    end
    $readmemh("tb/adc_xy_stim.txt", stim);
    while (num_rec < MAX_REC && stim[num_rec * 6] != 16'hffff) begin
      expect_q.push_back(map_record(num_rec));
      num_rec++;
    end
    // outputs change on rising edges, sampled in between
    forever begin
      @(negedge clk);
      if (rst_low) begin
        check_reset_values();
      end
      check_write();
      track_video();
    end
  end

  task automatic close_checks(output int n_write, output int n_sync,
                              output int n_video, output int n_reset);
    n_write = write_errs;
    n_sync  = sync_errs;
    n_video = video_errs;
    n_reset = reset_errs;
    if (writes_seen != num_rec) begin
      $display("saw %0d SRAM writes for %0d stim records", writes_seen, num_rec);
      n_write++;
    end
    if (!v_known) begin
      $display("no vsync pulse seen, video was never checked");
      n_sync++;
    end
  endtask

endmodule

/* tb/tb_adc_xy_vga.sv */
module tb_adc_xy_vga
  import adc_xy_pkg::*;
();

  localparam int MAX_REC = 32;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * PIX_DIV;
  // three frames plus margin
  localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 5000;

  logic      clk;
  logic      rst_n;
  logic      adc_clk;
  adc_word_t adc_x;
  adc_word_t adc_y;
  logic      adc_red;
  logic      adc_grn;
  logic      adc_blu;
  fb_addr_t  sram_addr;
  pixel_t    sram_data_out;
  pixel_t    sram_data_in;
  logic      sram_data_oe;
  logic      sram_we_n;
  logic      sram_oe_n;
  logic      sram_ce_n;
  color_t    vga_red;
  color_t    vga_grn;
  color_t    vga_blu;
  logic      vga_hsync;
  logic      vga_vsync;

  logic [15:0] stim [0:6*MAX_REC-1];
  pixel_t      sram_mem [0:4095];
  int          num_rec;
  int          cycles = 0;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  adc_xy_vga_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .adc_clk      (adc_clk),
    .adc_x        (adc_x),
    .adc_y        (adc_y),
    .adc_red      (adc_red),
    .adc_grn      (adc_grn),
    .adc_blu      (adc_blu),
    .sram_addr    (sram_addr),
    .sram_data_out(sram_data_out),
    .sram_data_in (sram_data_in),
    .sram_data_oe (sram_data_oe),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n),
    .vga_red      (vga_red),
    .vga_grn      (vga_grn),
    .vga_blu      (vga_blu),
    .vga_hsync    (vga_hsync),
    .vga_vsync    (vga_vsync)
  );

  adc_xy_vga_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .sram_addr    (sram_addr),
    .sram_data_out(sram_data_out),
    .sram_data_oe (sram_data_oe),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n),
    .vga_red      (vga_red),
    .vga_grn      (vga_grn),
    .vga_blu      (vga_blu),
    .vga_hsync    (vga_hsync),
    .vga_vsync    (vga_vsync)
  );

  bind fb_arbiter adc_xy_vga_properties u_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .phase       (phase),
    .plot_req    (plot_req),
    .plot_ack    (plot_ack),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_data_oe(sram_data_oe)
  );

  // async sram model with a combinational read
  initial begin
    for (int i = 0; i < 4096; i++) begin
      sram_mem[i] = '0;
    end
  end

  assign sram_data_in = (!sram_ce_n && !sram_oe_n) ? sram_mem[sram_addr] : '0;

  always @(posedge clk) begin
    if (!sram_ce_n && !sram_we_n && sram_data_oe) begin
      sram_mem[sram_addr] <= sram_data_out;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // values first, then the adc clock pulse, then the idle gap
  task automatic drive_record(input int idx);
    int base;
    base = idx * 6;
    @(negedge clk);
    adc_x   = adc_word_t'(stim[base]);
    adc_y   = adc_word_t'(stim[base+1]);
    adc_red = stim[base+2][0];
    adc_grn = stim[base+3][0];
    adc_blu = stim[base+4][0];
    @(negedge clk);
    adc_clk = 1'b1;
    repeat (4) @(negedge clk);
    adc_clk = 1'b0;
    repeat (stim[base+5]) @(negedge clk);
  endtask

  initial begin
    int n_write;
    int n_sync;
    int n_video;
    int n_reset;
    rst_n   = 1'b0;
    adc_clk = 1'b0;
    adc_x   = '0;
    adc_y   = '0;
    adc_red = 1'b0;
    adc_grn = 1'b0;
    adc_blu = 1'b0;
    for (int i = 0; i < 6 * MAX_REC; i++) begin
      stim[i] = 16'hffff;
    end
    $readmemh("tb/adc_xy_stim.txt", stim);
    num_rec = 0;
    while (num_rec < MAX_REC && stim[num_rec * 6] != 16'hffff) begin
      num_rec++;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (8) @(negedge clk);
    for (int i = 0; i < num_rec; i++) begin
      drive_record(i);
    end
    // a whole frame of video lies between two vsync pulses
    @(negedge vga_vsync);
    @(negedge vga_vsync);
    @(posedge clk);
    u_checker.close_checks(n_write, n_sync, n_video, n_reset);
    $display("errors: write %0d, sync %0d, video %0d, reset %0d",
             n_write, n_sync, n_video, n_reset);
    if (n_write + n_sync + n_video + n_reset == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb/adc_xy_stim.txt */
// columns: adc_x adc_y red green blue gap, all hex
// gap is the number of idle clk cycles after the adc clock pulse
000 000 1 1 1 20
3ff 3ff 1 0 0 20
105 203 0 1 0 20
// same point as the line above, blue should remain
10a 20c 0 0 1 20
200 100 1 1 0 18
2f0 3c0 1 0 1 18
040 080 0 1 1 18
// same point as 2f0 3c0, ends up white
2f8 3c8 1 1 1 18
0f0 155 1 0 0 18
1e0 2aa 0 0 0 18
120 360 0 1 0 18
3f0 000 0 0 1 18
00f 3ff 1 1 0 18
155 0aa 1 0 1 20

/* src.f */
verilog/adc_xy_pkg.sv
verilog/adc_sample.sv
verilog/fb_arbiter.sv
verilog/vga_timing.sv
verilog/vga_scanout.sv
verilog/adc_xy_vga_top.sv
tb/adc_xy_vga_properties.sv
tb/adc_xy_vga_checker.sv
tb/tb_adc_xy_vga.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_adc_xy_vga
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
